// File: common/issue_pkg.sv
package issue_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_width = 5;
  localparam int imm_width = 12;
  localparam int op_width = 3;

  localparam logic [op_width-1:0] op_nop = 3'd0;
  localparam logic [op_width-1:0] op_add = 3'd1;
  localparam logic [op_width-1:0] op_sub = 3'd2;
  localparam logic [op_width-1:0] op_and = 3'd3;
  localparam logic [op_width-1:0] op_xor = 3'd4;
  localparam logic [op_width-1:0] op_addi = 3'd5;
  localparam logic [op_width-1:0] op_load = 3'd6;
  localparam logic [op_width-1:0] op_store = 3'd7;

  // word addressed, byte address bits [1:0] ignored
  localparam int mem_depth = 256;
  localparam int mem_addr_width = $clog2(mem_depth);

endpackage

// File: rtl/register_file.sv
`timescale 1ns/1ps

module register_file (
  input  logic clock,
  input  logic reset,
  input  logic [issue_pkg::reg_addr_width-1:0] raddr0,
  input  logic [issue_pkg::reg_addr_width-1:0] raddr1,
  input  logic [issue_pkg::reg_addr_width-1:0] raddr2,
  input  logic [issue_pkg::reg_addr_width-1:0] raddr3,
  output logic [issue_pkg::xlen-1:0] rdata0,
  output logic [issue_pkg::xlen-1:0] rdata1,
  output logic [issue_pkg::xlen-1:0] rdata2,
  output logic [issue_pkg::xlen-1:0] rdata3,
  input  logic wen0,
  input  logic [issue_pkg::reg_addr_width-1:0] waddr0,
  input  logic [issue_pkg::xlen-1:0] wdata0,
  input  logic wen1,
  input  logic [issue_pkg::reg_addr_width-1:0] waddr1,
  input  logic [issue_pkg::xlen-1:0] wdata1
);

  logic [issue_pkg::xlen-1:0] regs [1:31];

  // x0 is never stored
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
  assign rdata3 = (raddr3 == '0) ? '0 : regs[raddr3];

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wen0 && waddr0 != '0) begin
        regs[waddr0] <= wdata0;
      end
      // port 1 is the younger slot, so it lands last
      if (wen1 && waddr1 != '0) begin
        regs[waddr1] <= wdata1;
      end
    end
  end

endmodule

// File: issue/hazard_check.sv
`timescale 1ns/1ps

module hazard_check (
  input  logic held0_valid,
  input  logic [issue_pkg::op_width-1:0] held0_op,
  input  logic [issue_pkg::reg_addr_width-1:0] held0_rd,
  input  logic [issue_pkg::reg_addr_width-1:0] held0_rs1,
  input  logic [issue_pkg::reg_addr_width-1:0] held0_rs2,
  input  logic held1_valid,
  input  logic [issue_pkg::op_width-1:0] held1_op,
  input  logic [issue_pkg::reg_addr_width-1:0] held1_rs1,
  input  logic [issue_pkg::reg_addr_width-1:0] held1_rs2,
  input  logic ex0_valid,
  input  logic [issue_pkg::op_width-1:0] ex0_op,
  input  logic [issue_pkg::reg_addr_width-1:0] ex0_rd,
  input  logic ex1_valid,
  input  logic [issue_pkg::op_width-1:0] ex1_op,
  input  logic [issue_pkg::reg_addr_width-1:0] ex1_rd,
  input  logic mem0_valid,
  input  logic [issue_pkg::op_width-1:0] mem0_op,
  input  logic [issue_pkg::reg_addr_width-1:0] mem0_rd,
  input  logic mem1_valid,
  input  logic [issue_pkg::op_width-1:0] mem1_op,
  input  logic [issue_pkg::reg_addr_width-1:0] mem1_rd,
  output logic issue0,
  output logic issue1
);

  logic [3:0] stage_wr;
  logic [3:0][issue_pkg::reg_addr_width-1:0] stage_rd;
  logic stall0;
  logic stall1;
  logic pair_dep;
  logic pair_mem;

  function automatic logic writes(input logic [issue_pkg::op_width-1:0] op);
    return op != issue_pkg::op_nop && op != issue_pkg::op_store;
  endfunction

  function automatic logic uses_rs1(input logic [issue_pkg::op_width-1:0] op);
    return op != issue_pkg::op_nop;
  endfunction

  function automatic logic uses_rs2(input logic [issue_pkg::op_width-1:0] op);
    return op inside {issue_pkg::op_add, issue_pkg::op_sub, issue_pkg::op_and,
                      issue_pkg::op_xor, issue_pkg::op_store};
  endfunction

  function automatic logic is_mem(input logic [issue_pkg::op_width-1:0] op);
    return op == issue_pkg::op_load || op == issue_pkg::op_store;
  endfunction

  function automatic logic blocked(input logic [issue_pkg::reg_addr_width-1:0] src,
                                   input logic [3:0] wr,
                                   input logic [3:0][issue_pkg::reg_addr_width-1:0] rd);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (wr[i] && rd[i] == src) begin
        hit = 1'b1;
      end
    end
    return hit && src != '0;
  endfunction

  // ex slots first, then mem slots
  assign stage_wr = {mem1_valid && writes(mem1_op), mem0_valid && writes(mem0_op),
                     ex1_valid && writes(ex1_op), ex0_valid && writes(ex0_op)};
  assign stage_rd = {mem1_rd, mem0_rd, ex1_rd, ex0_rd};

  assign stall0 = (uses_rs1(held0_op) && blocked(held0_rs1, stage_wr, stage_rd)) ||
                  (uses_rs2(held0_op) && blocked(held0_rs2, stage_wr, stage_rd));
  assign stall1 = (uses_rs1(held1_op) && blocked(held1_rs1, stage_wr, stage_rd)) ||
                  (uses_rs2(held1_op) && blocked(held1_rs2, stage_wr, stage_rd));

  // no forwarding inside the pair
  assign pair_dep = writes(held0_op) && held0_rd != '0 &&
                    ((uses_rs1(held1_op) && held1_rs1 == held0_rd) ||
                     (uses_rs2(held1_op) && held1_rs2 == held0_rd));
  assign pair_mem = is_mem(held0_op) && is_mem(held1_op);

  assign issue0 = held0_valid && !stall0;
  assign issue1 = issue0 && held1_valid && !stall1 && !pair_dep && !pair_mem;

endmodule

// File: issue/issue_stage.sv
`timescale 1ns/1ps

module issue_stage (
  input  logic clock,
  input  logic reset,
  input  logic in_valid,
  output logic in_ready,
  input  logic slot1_valid,
  input  logic [issue_pkg::op_width-1:0] in0_op,
  input  logic [issue_pkg::reg_addr_width-1:0] in0_rd,
  input  logic [issue_pkg::reg_addr_width-1:0] in0_rs1,
  input  logic [issue_pkg::reg_addr_width-1:0] in0_rs2,
  input  logic [issue_pkg::imm_width-1:0] in0_imm,
  input  logic [issue_pkg::op_width-1:0] in1_op,
  input  logic [issue_pkg::reg_addr_width-1:0] in1_rd,
  input  logic [issue_pkg::reg_addr_width-1:0] in1_rs1,
  input  logic [issue_pkg::reg_addr_width-1:0] in1_rs2,
  input  logic [issue_pkg::imm_width-1:0] in1_imm,
  output logic [issue_pkg::reg_addr_width-1:0] raddr0,
  output logic [issue_pkg::reg_addr_width-1:0] raddr1,
  output logic [issue_pkg::reg_addr_width-1:0] raddr2,
  output logic [issue_pkg::reg_addr_width-1:0] raddr3,
  input  logic [issue_pkg::xlen-1:0] rdata0,
  input  logic [issue_pkg::xlen-1:0] rdata1,
  input  logic [issue_pkg::xlen-1:0] rdata2,
  input  logic [issue_pkg::xlen-1:0] rdata3,
  input  logic issue0,
  input  logic issue1,
  output logic held0_valid,
  output logic [issue_pkg::op_width-1:0] held0_op,
  output logic [issue_pkg::reg_addr_width-1:0] held0_rd,
  output logic [issue_pkg::reg_addr_width-1:0] held0_rs1,
  output logic [issue_pkg::reg_addr_width-1:0] held0_rs2,
  output logic held1_valid,
  output logic [issue_pkg::op_width-1:0] held1_op,
  output logic [issue_pkg::reg_addr_width-1:0] held1_rs1,
  output logic [issue_pkg::reg_addr_width-1:0] held1_rs2,
  output logic ex0_valid,
  output logic [issue_pkg::op_width-1:0] ex0_op,
  output logic [issue_pkg::reg_addr_width-1:0] ex0_rd,
  output logic [issue_pkg::xlen-1:0] ex0_a,
  output logic [issue_pkg::xlen-1:0] ex0_b,
  output logic [issue_pkg::imm_width-1:0] ex0_imm,
  output logic ex1_valid,
  output logic [issue_pkg::op_width-1:0] ex1_op,
  output logic [issue_pkg::reg_addr_width-1:0] ex1_rd,
  output logic [issue_pkg::xlen-1:0] ex1_a,
  output logic [issue_pkg::xlen-1:0] ex1_b,
  output logic [issue_pkg::imm_width-1:0] ex1_imm
);

  logic [issue_pkg::imm_width-1:0] held0_imm;
  logic [issue_pkg::reg_addr_width-1:0] held1_rd;
  logic [issue_pkg::imm_width-1:0] held1_imm;
  logic running;
  logic accept;
  logic shift;

  // ready once the holding register drains this cycle
  assign in_ready = running && (!held0_valid || (issue0 && (!held1_valid || issue1)));
  assign accept = in_valid && in_ready;
  // slot 0 left alone, slot 1 moves up to keep program order
  assign shift = issue0 && !issue1 && held1_valid;

  assign raddr0 = held0_rs1;
  assign raddr1 = held0_rs2;
  assign raddr2 = held1_rs1;
  assign raddr3 = held1_rs2;

  always_ff @(posedge clock) begin
    if (!reset) begin
      running <= 1'b0;
      held0_valid <= 1'b0;
      held1_valid <= 1'b0;
      ex0_valid <= 1'b0;
      ex1_valid <= 1'b0;
    end else begin
      running <= 1'b1;
      if (accept) begin
        held0_valid <= 1'b1;
        held1_valid <= slot1_valid;
      end else if (shift) begin
        held1_valid <= 1'b0;
      end else if (issue0) begin
        held0_valid <= 1'b0;
        held1_valid <= 1'b0;
      end
      ex0_valid <= issue0;
      ex1_valid <= issue1;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      held0_op <= in0_op;
      held0_rd <= in0_rd;
      held0_rs1 <= in0_rs1;
      held0_rs2 <= in0_rs2;
      held0_imm <= in0_imm;
      held1_op <= in1_op;
      held1_rd <= in1_rd;
      held1_rs1 <= in1_rs1;
      held1_rs2 <= in1_rs2;
      held1_imm <= in1_imm;
    end else if (shift) begin
      held0_op <= held1_op;
      held0_rd <= held1_rd;
      held0_rs1 <= held1_rs1;
      held0_rs2 <= held1_rs2;
      held0_imm <= held1_imm;
    end
    ex0_op <= held0_op;
    ex0_rd <= held0_rd;
    ex0_a <= rdata0;
    ex0_b <= rdata1;
    ex0_imm <= held0_imm;
    ex1_op <= held1_op;
    ex1_rd <= held1_rd;
    ex1_a <= rdata2;
    ex1_b <= rdata3;
    ex1_imm <= held1_imm;
  end

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic clock,
  input  logic reset,
  input  logic ex0_valid,
  input  logic [issue_pkg::op_width-1:0] ex0_op,
  input  logic [issue_pkg::reg_addr_width-1:0] ex0_rd,
  input  logic [issue_pkg::xlen-1:0] ex0_a,
  input  logic [issue_pkg::xlen-1:0] ex0_b,
  input  logic [issue_pkg::imm_width-1:0] ex0_imm,
  input  logic ex1_valid,
  input  logic [issue_pkg::op_width-1:0] ex1_op,
  input  logic [issue_pkg::reg_addr_width-1:0] ex1_rd,
  input  logic [issue_pkg::xlen-1:0] ex1_a,
  input  logic [issue_pkg::xlen-1:0] ex1_b,
  input  logic [issue_pkg::imm_width-1:0] ex1_imm,
  output logic mem0_valid,
  output logic [issue_pkg::op_width-1:0] mem0_op,
  output logic [issue_pkg::reg_addr_width-1:0] mem0_rd,
  output logic [issue_pkg::xlen-1:0] mem0_result,
  output logic [issue_pkg::xlen-1:0] mem0_store_data,
  output logic mem1_valid,
  output logic [issue_pkg::op_width-1:0] mem1_op,
  output logic [issue_pkg::reg_addr_width-1:0] mem1_rd,
  output logic [issue_pkg::xlen-1:0] mem1_result,
  output logic [issue_pkg::xlen-1:0] mem1_store_data
);

  function automatic logic [issue_pkg::xlen-1:0] alu(
      input logic [issue_pkg::op_width-1:0] op,
      input logic [issue_pkg::xlen-1:0] a,
      input logic [issue_pkg::xlen-1:0] b,
      input logic [issue_pkg::imm_width-1:0] imm);
    logic [issue_pkg::xlen-1:0] imm_ext;
    imm_ext = {{(issue_pkg::xlen - issue_pkg::imm_width){imm[issue_pkg::imm_width-1]}}, imm};
    case (op)
      issue_pkg::op_add: return a + b;
      issue_pkg::op_sub: return a - b;
      issue_pkg::op_and: return a & b;
      issue_pkg::op_xor: return a ^ b;
      // addi and address generation share the adder
      issue_pkg::op_addi, issue_pkg::op_load, issue_pkg::op_store: return a + imm_ext;
      default: return '0;
    endcase
  endfunction

  always_ff @(posedge clock) begin
    if (!reset) begin
      mem0_valid <= 1'b0;
      mem1_valid <= 1'b0;
    end else begin
      mem0_valid <= ex0_valid;
      mem1_valid <= ex1_valid;
    end
  end

  always_ff @(posedge clock) begin
    mem0_op <= ex0_op;
    mem0_rd <= ex0_rd;
    mem0_result <= alu(ex0_op, ex0_a, ex0_b, ex0_imm);
    mem0_store_data <= ex0_b;
    mem1_op <= ex1_op;
    mem1_rd <= ex1_rd;
    mem1_result <= alu(ex1_op, ex1_a, ex1_b, ex1_imm);
    mem1_store_data <= ex1_b;
  end

endmodule

// File: rtl/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
  input  logic clock,
  input  logic reset,
  input  logic mem0_valid,
  input  logic [issue_pkg::op_width-1:0] mem0_op,
  input  logic [issue_pkg::reg_addr_width-1:0] mem0_rd,
  input  logic [issue_pkg::xlen-1:0] mem0_result,
  input  logic [issue_pkg::xlen-1:0] mem0_store_data,
  input  logic mem1_valid,
  input  logic [issue_pkg::op_width-1:0] mem1_op,
  input  logic [issue_pkg::reg_addr_width-1:0] mem1_rd,
  input  logic [issue_pkg::xlen-1:0] mem1_result,
  input  logic [issue_pkg::xlen-1:0] mem1_store_data,
  output logic retire0_valid,
  output logic [issue_pkg::reg_addr_width-1:0] retire0_rd,
  output logic [issue_pkg::xlen-1:0] retire0_data,
  output logic retire0_write,
  output logic retire1_valid,
  output logic [issue_pkg::reg_addr_width-1:0] retire1_rd,
  output logic [issue_pkg::xlen-1:0] retire1_data,
  output logic retire1_write,
  output logic wen0,
  output logic [issue_pkg::reg_addr_width-1:0] waddr0,
  output logic [issue_pkg::xlen-1:0] wdata0,
  output logic wen1,
  output logic [issue_pkg::reg_addr_width-1:0] waddr1,
  output logic [issue_pkg::xlen-1:0] wdata1
);

  logic [issue_pkg::xlen-1:0] data_mem [issue_pkg::mem_depth];
  logic slot0_mem;
  logic [issue_pkg::xlen-1:0] addr;
  logic [issue_pkg::mem_addr_width-1:0] index;
  logic [issue_pkg::xlen-1:0] load_data;
  logic store_en;

  // at most one slot carries a memory op
  assign slot0_mem = mem0_op == issue_pkg::op_load || mem0_op == issue_pkg::op_store;
  assign addr = slot0_mem ? mem0_result : mem1_result;
  assign index = addr[issue_pkg::mem_addr_width+1:2];
  assign load_data = data_mem[index];
  assign store_en = (mem0_valid && mem0_op == issue_pkg::op_store) ||
                    (mem1_valid && mem1_op == issue_pkg::op_store);

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < issue_pkg::mem_depth; i++) begin
        data_mem[i] <= '0;
      end
    end else if (store_en) begin
      data_mem[index] <= slot0_mem ? mem0_store_data : mem1_store_data;
    end
  end

  // register file writes land on the same edge as the retire register
  assign wen0 = mem0_valid && mem0_op != issue_pkg::op_store;
  assign waddr0 = mem0_rd;
  assign wdata0 = (mem0_op == issue_pkg::op_load) ? load_data : mem0_result;
  assign wen1 = mem1_valid && mem1_op != issue_pkg::op_store;
  assign waddr1 = mem1_rd;
  assign wdata1 = (mem1_op == issue_pkg::op_load) ? load_data : mem1_result;

  always_ff @(posedge clock) begin
    if (!reset) begin
      retire0_valid <= 1'b0;
      retire0_write <= 1'b0;
      retire1_valid <= 1'b0;
      retire1_write <= 1'b0;
    end else begin
      retire0_valid <= mem0_valid;
      retire0_write <= wen0;
      retire1_valid <= mem1_valid;
      retire1_write <= wen1;
    end
  end

  always_ff @(posedge clock) begin
    retire0_rd <= waddr0;
    retire0_data <= wdata0;
    retire1_rd <= waddr1;
    retire1_data <= wdata1;
  end

endmodule

// File: rtl/dual_issue_core.sv
`timescale 1ns/1ps

module dual_issue_core (
  input  logic clock,
  input  logic reset,
  input  logic in_valid,
  output logic in_ready,
  input  logic slot1_valid,
  input  logic [issue_pkg::op_width-1:0] in0_op,
  input  logic [issue_pkg::reg_addr_width-1:0] in0_rd,
  input  logic [issue_pkg::reg_addr_width-1:0] in0_rs1,
  input  logic [issue_pkg::reg_addr_width-1:0] in0_rs2,
  input  logic [issue_pkg::imm_width-1:0] in0_imm,
  input  logic [issue_pkg::op_width-1:0] in1_op,
  input  logic [issue_pkg::reg_addr_width-1:0] in1_rd,
  input  logic [issue_pkg::reg_addr_width-1:0] in1_rs1,
  input  logic [issue_pkg::reg_addr_width-1:0] in1_rs2,
  input  logic [issue_pkg::imm_width-1:0] in1_imm,
  output logic retire0_valid,
  output logic [issue_pkg::reg_addr_width-1:0] retire0_rd,
  output logic [issue_pkg::xlen-1:0] retire0_data,
  output logic retire0_write,
  output logic retire1_valid,
  output logic [issue_pkg::reg_addr_width-1:0] retire1_rd,
  output logic [issue_pkg::xlen-1:0] retire1_data,
  output logic retire1_write
);

  logic [issue_pkg::reg_addr_width-1:0] raddr0, raddr1, raddr2, raddr3;
  logic [issue_pkg::xlen-1:0] rdata0, rdata1, rdata2, rdata3;
  logic issue0, issue1;

  logic held0_valid, held1_valid;
  logic [issue_pkg::op_width-1:0] held0_op, held1_op;
  logic [issue_pkg::reg_addr_width-1:0] held0_rd, held0_rs1, held0_rs2;
  logic [issue_pkg::reg_addr_width-1:0] held1_rs1, held1_rs2;

  logic ex0_valid, ex1_valid;
  logic [issue_pkg::op_width-1:0] ex0_op, ex1_op;
  logic [issue_pkg::reg_addr_width-1:0] ex0_rd, ex1_rd;
  logic [issue_pkg::xlen-1:0] ex0_a, ex0_b, ex1_a, ex1_b;
  logic [issue_pkg::imm_width-1:0] ex0_imm, ex1_imm;

  logic mem0_valid, mem1_valid;
  logic [issue_pkg::op_width-1:0] mem0_op, mem1_op;
  logic [issue_pkg::reg_addr_width-1:0] mem0_rd, mem1_rd;
  logic [issue_pkg::xlen-1:0] mem0_result, mem0_store_data;
  logic [issue_pkg::xlen-1:0] mem1_result, mem1_store_data;

  logic wen0, wen1;
  logic [issue_pkg::reg_addr_width-1:0] waddr0, waddr1;
  logic [issue_pkg::xlen-1:0] wdata0, wdata1;

  // port names match across the pipeline
  issue_stage u_issue (.*);
  hazard_check u_hazard (.*);
  register_file u_regs (.*);
  execute_stage u_execute (.*);
  memory_stage u_memory (.*);

endmodule

// File: dv/dual_issue_tb.sv
`timescale 1ns/1ps

module dual_issue_tb;

  // instruction packing {op, rd, rs1, rs2, imm}
  localparam int instr_width = 30;
  localparam int max_instrs = 91;
  localparam int timeout_cycles = 6 * max_instrs + 50;
  localparam int drain_cycles = 30;

  logic clock;
  logic reset;
  logic in_valid;
  logic in_ready;
  logic slot1_valid;
  logic [issue_pkg::op_width-1:0] in0_op, in1_op;
  logic [issue_pkg::reg_addr_width-1:0] in0_rd, in0_rs1, in0_rs2;
  logic [issue_pkg::reg_addr_width-1:0] in1_rd, in1_rs1, in1_rs2;
  logic [issue_pkg::imm_width-1:0] in0_imm, in1_imm;
  logic retire0_valid, retire0_write, retire1_valid, retire1_write;
  logic [issue_pkg::reg_addr_width-1:0] retire0_rd, retire1_rd;
  logic [issue_pkg::xlen-1:0] retire0_data, retire1_data;

  logic [issue_pkg::xlen-1:0] model_regs [32];
  logic [issue_pkg::xlen-1:0] model_mem [issue_pkg::mem_depth];
  // {write, rd, data}
  logic [37:0] expected [$];
  int errors;
  int cycle_count;

  dual_issue_core u_dual_issue_core (.*);

  always #4 clock = ~clock;

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout after %0d cycles, retires did not finish", cycle_count);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [instr_width-1:0] instr(input logic [2:0] op, input logic [4:0] rd,
                                                   input logic [4:0] rs1, input logic [4:0] rs2,
                                                   input logic [11:0] imm);
    return {op, rd, rs1, rs2, imm};
  endfunction

  // in-order reference model with x0 held at zero
  task automatic model_step(input logic [instr_width-1:0] i);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_ext;
    logic [31:0] res;
    logic [7:0] idx;
    a = (i[21:17] == 0) ? 32'h0 : model_regs[i[21:17]];
    b = (i[16:12] == 0) ? 32'h0 : model_regs[i[16:12]];
    imm_ext = {{20{i[11]}}, i[11:0]};
    idx = (a + imm_ext) >> 2;
    res = 32'h0;
    case (i[29:27])
      issue_pkg::op_add: res = a + b;
      issue_pkg::op_sub: res = a - b;
      issue_pkg::op_and: res = a & b;
      issue_pkg::op_xor: res = a ^ b;
      issue_pkg::op_addi: res = a + imm_ext;
      issue_pkg::op_load: res = model_mem[idx];
      issue_pkg::op_store: model_mem[idx] = b;
      default: res = 32'h0;
    endcase
    if (i[29:27] != issue_pkg::op_store && i[26:22] != 0) begin
      model_regs[i[26:22]] = res;
    end
    expected.push_back({i[29:27] != issue_pkg::op_store, i[26:22], res});
  endtask

  // called and returns on a falling edge, after the accepting edge
  task automatic send_pair(input logic [instr_width-1:0] i0, input logic s1,
                           input logic [instr_width-1:0] i1);
    model_step(i0);
    if (s1) begin
      model_step(i1);
    end
    {in0_op, in0_rd, in0_rs1, in0_rs2, in0_imm} = i0;
    {in1_op, in1_rd, in1_rs1, in1_rs2, in1_imm} = i1;
    slot1_valid = s1;
    in_valid = 1'b1;
    while (!in_ready) begin
      @(negedge clock);
    end
    @(negedge clock);
    in_valid = 1'b0;
  endtask

  task automatic check_retire(input string port, input logic [4:0] rd, input logic [31:0] data,
                              input logic write);
    logic [37:0] exp;
    if (expected.size() == 0) begin
      $display("%s retired an instruction that was never sent", port);
      errors++;
    end else begin
      exp = expected.pop_front();
      if (write != exp[37]) begin
        $display("Fail %s_write: got %h expected %h", port, write, exp[37]);
        errors++;
      end
      if (exp[37] && rd != exp[36:32]) begin
        $display("Fail %s_rd: got %h expected %h", port, rd, exp[36:32]);
        errors++;
      end
      if (exp[37] && exp[36:32] != 0 && data != exp[31:0]) begin
        $display("Fail %s_data: got %h expected %h", port, data, exp[31:0]);
        errors++;
      end
    end
  endtask

  always @(negedge clock) begin
    if (retire0_valid) begin
      check_retire("retire0", retire0_rd, retire0_data, retire0_write);
    end
    if (retire1_valid) begin
      check_retire("retire1", retire1_rd, retire1_data, retire1_write);
    end
  end

  // bounded so that missing retires reach the closing queue check
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (expected.size() != 0 && waited < drain_cycles) begin
      @(negedge clock);
      waited++;
    end
    @(negedge clock);
  endtask

  task automatic independent_pair();
    int latency;
    latency = 0;
    send_pair(instr(issue_pkg::op_addi, 1, 0, 0, 12'h123), 1'b1,
              instr(issue_pkg::op_addi, 2, 0, 0, 12'hffb));
    while (!retire0_valid) begin
      @(negedge clock);
      latency++;
    end
    if (latency < 3) begin
      $display("first retire came %0d cycles after acceptance, earlier than allowed", latency);
      errors++;
    end
    if (!retire1_valid) begin
      $display("independent pair did not retire both slots in the same cycle");
      errors++;
    end
    wait_drain();
  endtask

  task automatic intra_pair_dependency();
    send_pair(instr(issue_pkg::op_add, 3, 1, 2, 12'h0), 1'b1,
              instr(issue_pkg::op_sub, 4, 3, 1, 12'h0));
    while (!retire0_valid) begin
      @(negedge clock);
    end
    if (retire1_valid) begin
      $display("dependent pair retired together instead of splitting");
      errors++;
    end
    wait_drain();
  endtask

  task automatic cross_pair_raw();
    send_pair(instr(issue_pkg::op_addi, 5, 1, 0, 12'h011), 1'b1,
              instr(issue_pkg::op_addi, 6, 0, 0, 12'h7ff));
    send_pair(instr(issue_pkg::op_xor, 7, 5, 2, 12'h0), 1'b0,
              instr(issue_pkg::op_nop, 0, 0, 0, 12'h0));
    if (in_ready) begin
      $display("in_ready stayed high while the xor waited on x5");
      errors++;
    end
    wait_drain();
  endtask

  task automatic memory_ops();
    send_pair(instr(issue_pkg::op_store, 9, 0, 2, 12'h010), 1'b0,
              instr(issue_pkg::op_nop, 0, 0, 0, 12'h0));
    send_pair(instr(issue_pkg::op_load, 9, 0, 0, 12'h010), 1'b0,
              instr(issue_pkg::op_nop, 0, 0, 0, 12'h0));
    send_pair(instr(issue_pkg::op_store, 0, 0, 1, 12'h020), 1'b1,
              instr(issue_pkg::op_load, 10, 0, 0, 12'h020));
    wait_drain();
  endtask

  function automatic logic [instr_width-1:0] random_instr();
    logic [2:0] op;
    op = $urandom_range(7, 1);
    if (op == issue_pkg::op_load || op == issue_pkg::op_store) begin
      // 16 words based at x0
      return instr(op, $urandom_range(7, 0), 0, $urandom_range(7, 0),
                   $urandom_range(15, 0) * 4);
    end
    return instr(op, $urandom_range(7, 0), $urandom_range(7, 0), $urandom_range(7, 0),
                 $urandom);
  endfunction

  task automatic random_stream();
    int gap;
    for (int p = 0; p < 40; p++) begin
      gap = $urandom_range(2, 0);
      repeat (gap) @(negedge clock);
      send_pair(random_instr(), $urandom_range(1, 0), random_instr());
    end
    wait_drain();
  endtask

  initial begin
    void'($urandom(32'he621));
    clock = 1'b0;
    reset = 1'b0;
    in_valid = 1'b0;
    slot1_valid = 1'b0;
    {in0_op, in0_rd, in0_rs1, in0_rs2, in0_imm} = '0;
    {in1_op, in1_rd, in1_rs1, in1_rs2, in1_imm} = '0;
    errors = 0;
    cycle_count = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = 32'h0;
    end
    for (int i = 0; i < issue_pkg::mem_depth; i++) begin
      model_mem[i] = 32'h0;
    end
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    independent_pair();
    intra_pair_dependency();
    cross_pair_raw();
    memory_ops();
    random_stream();
    repeat (4) @(negedge clock);
    if (expected.size() != 0) begin
      $display("%0d expected retires never arrived", expected.size());
      errors++;
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
common/issue_pkg.sv
rtl/register_file.sv
issue/hazard_check.sv
issue/issue_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/dual_issue_core.sv
dv/dual_issue_tb.sv
